// ==== bench/island_clk_gen.sv ====
/*
 * Bench clock and reset
 * 100 ns clock, active-low reset held for a fixed number of cycles
 */

module island_clk_gen #(
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== bench/island_tb.sv ====
/*
 * Safety island testbench
 * Random and directed Wishbone accesses checked against a reference model
 */

module island_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ResetCycles = 8;
  localparam int unsigned NumWords    = 32;
  localparam int unsigned NumPartial  = 16;
  localparam int unsigned NumRom      = 16;
  localparam int unsigned NumBad      = 12;
  localparam int unsigned NumRecheck  = 8;
  localparam int unsigned TotalTxn    = 2 * NumWords + 4 + 2 * NumPartial + 10 + NumRom + 2 +
                                        NumBad + NumRecheck + 2;
  localparam int unsigned TimeoutCycles = ResetCycles + 4 * TotalTxn + 50;

  localparam logic [31:0] RegsBase  = island_map_pkg::PeriphBase + island_map_pkg::SocCtrlOffset;
  localparam logic [31:0] RomBase   = island_map_pkg::PeriphBase + island_map_pkg::BootRomOffset;
  localparam logic [19:0] Bank0Page = island_map_pkg::Bank0Base[31:12];
  localparam logic [19:0] Bank1Page = island_map_pkg::Bank1Base[31:12];
  localparam logic [19:0] RegsPage  = RegsBase[31:12];
  localparam logic [19:0] RomPage   = RomBase[31:12];

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic        fetch_en;
  logic [31:0] boot_addr;

  // Reference model state
  logic [31:0] bank0_m [1024];
  logic [31:0] bank1_m [1024];
  logic        fetch_en_m;
  logic [31:0] boot_addr_m;

  // One entry per outstanding request
  logic        exp_err_q   [$];
  logic [31:0] exp_data_q  [$];
  logic        exp_check_q [$];
  int unsigned exp_start_q [$];
  logic [31:0] exp_adr_q   [$];

  logic [31:0] lfsr_state = 32'hbf57_da32;
  int unsigned cycle;
  int unsigned checks;
  int unsigned data_errors;
  int unsigned protocol_errors;

  island_clk_gen #(.ResetCycles(ResetCycles)) i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  island_top dut0 (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .wb_cyc_i    ( wb_cyc    ),
    .wb_stb_i    ( wb_stb    ),
    .wb_we_i     ( wb_we     ),
    .wb_sel_i    ( wb_sel    ),
    .wb_adr_i    ( wb_adr    ),
    .wb_dat_i    ( wb_dat_w  ),
    .wb_dat_o    ( wb_dat_r  ),
    .wb_ack_o    ( wb_ack    ),
    .wb_err_o    ( wb_err    ),
    .fetch_en_o  ( fetch_en  ),
    .boot_addr_o ( boot_addr )
  );

  // ------------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic next_lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] m;
    m = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        m[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return m;
  endfunction

  // Returns {err, read data} and applies any write to the model
  function automatic logic [32:0] ref_access(input logic we, input logic [3:0] sel,
                                             input logic [31:0] adr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic [9:0]  word;
    rd   = '0;
    word = adr[11:2];
    case (adr[31:12])
      Bank0Page: begin
        rd = bank0_m[word];
        if (we) bank0_m[word] = merge_bytes(rd, wdata, sel);
      end
      Bank1Page: begin
        rd = bank1_m[word];
        if (we) bank1_m[word] = merge_bytes(rd, wdata, sel);
      end
      RegsPage: begin
        if (adr[11:0] == 12'h000) begin
          rd = {31'b0, fetch_en_m};
          if (we && sel[0]) fetch_en_m = wdata[0];
        end else if (adr[11:0] == 12'h004) begin
          rd = boot_addr_m;
          if (we) boot_addr_m = merge_bytes(rd, wdata, sel);
        end
      end
      RomPage: rd = island_map_pkg::BootRomTable[word % island_map_pkg::RomWords];
      default: return {1'b1, 32'hBADCAB1E};
    endcase
    return {1'b0, rd};
  endfunction

  // One classic cycle held until ack or err
  task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                            input logic [31:0] wdata);
    logic [32:0] exp;
    @(posedge clk);
    exp = ref_access(we, sel, adr, wdata);
    exp_err_q.push_back(exp[32]);
    exp_data_q.push_back(exp[31:0]);
    exp_check_q.push_back(!we || exp[32]);
    exp_start_q.push_back(cycle + 1);
    exp_adr_q.push_back(adr);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_sel   <= sel;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do @(posedge clk); while (!(wb_ack || wb_err));
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  initial begin : stimulus
    logic [31:0] addr_list [$];
    logic [31:0] adr;
    logic [31:0] rnd;
    logic [31:0] rnd2;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_sel      = '0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    fetch_en_m  = 1'b0;
    boot_addr_m = RomBase + 32'h80;
    wait (rst_n);
    @(posedge clk);
    assert (fetch_en == 1'b0 && boot_addr == RomBase + 32'h80) else begin
      data_errors++;
      $display("error %0t ns: reset outputs fetch_en %b boot_addr %h",
               $time, fetch_en, boot_addr);
    end

    // Full words in both banks followed by readback
    for (int i = 0; i < NumWords; i++) begin
      rnd = random_bits(11);
      adr = {19'b0, rnd[10:0], 2'b00};
      bus_access(1'b1, 4'hf, adr, random_bits(32));
      addr_list.push_back(adr);
    end
    foreach (addr_list[i]) begin
      bus_access(1'b0, 4'hf, addr_list[i], '0);
    end
    // Same word index in each bank
    bus_access(1'b1, 4'hf, island_map_pkg::Bank0Base + 32'h40, 32'h1111_0000);
    bus_access(1'b1, 4'hf, island_map_pkg::Bank1Base + 32'h40, 32'h2222_ffff);
    bus_access(1'b0, 4'hf, island_map_pkg::Bank0Base + 32'h40, '0);
    bus_access(1'b0, 4'hf, island_map_pkg::Bank1Base + 32'h40, '0);

    // Partial byte selects
    for (int i = 0; i < NumPartial; i++) begin
      rnd  = random_bits(5);
      adr  = addr_list[rnd[4:0] % NumWords];
      rnd2 = random_bits(4);
      bus_access(1'b1, rnd2[3:0], adr, random_bits(32));
      bus_access(1'b0, 4'hf, adr, '0);
    end

    // SoC control registers
    bus_access(1'b0, 4'hf, RegsBase, '0);
    bus_access(1'b0, 4'hf, RegsBase + 32'h4, '0);
    bus_access(1'b1, 4'b0001, RegsBase, 32'h0000_0001);
    bus_access(1'b0, 4'hf, RegsBase, '0);
    bus_access(1'b1, 4'hf, RegsBase + 32'h4, random_bits(32));
    bus_access(1'b0, 4'hf, RegsBase + 32'h4, '0);
    bus_access(1'b1, 4'b0110, RegsBase + 32'h4, random_bits(32));
    bus_access(1'b0, 4'hf, RegsBase + 32'h4, '0);
    bus_access(1'b1, 4'hf, RegsBase + 32'h8, random_bits(32));
    bus_access(1'b0, 4'hf, RegsBase + 32'h8, '0);

    // Boot ROM reads across the aliased window
    for (int i = 0; i < NumRom; i++) begin
      rnd = random_bits(10);
      bus_access(1'b0, 4'hf, RomBase + {20'b0, rnd[9:0], 2'b00}, '0);
    end
    bus_access(1'b1, 4'hf, RomBase + 32'hc, random_bits(32));
    bus_access(1'b0, 4'hf, RomBase + 32'hc, '0);

    // Unmapped addresses and a recheck of earlier state
    for (int i = 0; i < NumBad; i++) begin
      rnd  = random_bits(32);
      rnd2 = random_bits(1);
      case (i % 3)
        0:       adr = {1'b1, rnd[30:0]};
        1:       adr = {19'h00001, rnd[12:0]};
        default: adr = {16'h0020, 4'h2, rnd[11:0]};
      endcase
      bus_access(rnd2[0], 4'hf, adr, random_bits(32));
    end
    for (int i = 0; i < NumRecheck; i++) begin
      bus_access(1'b0, 4'hf, addr_list[i], '0);
    end
    bus_access(1'b0, 4'hf, RegsBase, '0);
    bus_access(1'b0, 4'hf, RegsBase + 32'h4, '0);

    repeat (4) @(posedge clk);
    $display("checks %0d, data errors %0d, protocol errors %0d",
             checks, data_errors, protocol_errors);
    if (data_errors == 0 && protocol_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // ------------------------------------------------------------------
  // Response checking
  // ------------------------------------------------------------------

  always @(posedge clk) begin : compare
    logic        exp_err;
    logic [31:0] exp_data;
    logic        exp_check;
    int unsigned exp_start;
    logic [31:0] exp_adr;
    if (rst_n) begin
      assert (!(wb_ack && wb_err)) else begin
        protocol_errors++;
        $display("ack and err were high in the same cycle at %0t ns", $time);
      end
      if (wb_ack || wb_err) begin
        if (exp_err_q.size() == 0) begin
          protocol_errors++;
          $display("response at %0t ns with no request outstanding", $time);
        end else begin
          exp_err   = exp_err_q.pop_front();
          exp_data  = exp_data_q.pop_front();
          exp_check = exp_check_q.pop_front();
          exp_start = exp_start_q.pop_front();
          exp_adr   = exp_adr_q.pop_front();
          checks++;
          assert (wb_err == exp_err) else begin
            data_errors++;
            $display("error %0t ns: %h gave err %b, expected %b",
                     $time, exp_adr, wb_err, exp_err);
          end
          if (exp_check) begin
            assert (wb_dat_r == exp_data) else begin
              data_errors++;
              $display("error %0t ns: %h read %h, expected %h",
                       $time, exp_adr, wb_dat_r, exp_data);
            end
          end
          assert (cycle - exp_start == 2) else begin
            protocol_errors++;
            $display("response to %h took %0d cycles instead of 2", exp_adr, cycle - exp_start);
          end
          assert (fetch_en == fetch_en_m && boot_addr == boot_addr_m) else begin
            data_errors++;
            $display("error %0t ns: fetch_en %b boot_addr %h, expected %b %h",
                     $time, fetch_en, boot_addr, fetch_en_m, boot_addr_m);
          end
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("run did not finish within %0d cycles", TimeoutCycles);
      $display("checks %0d, data errors %0d, protocol errors %0d",
               checks, data_errors, protocol_errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

// ==== island.f ====
rtl/island_bus_pkg.sv
rtl/island_map_pkg.sv
rtl/island_sram_bank.sv
rtl/island_soc_regs.sv
rtl/island_boot_rom.sv
rtl/island_bus_ctrl.sv
rtl/island_top.sv
bench/island_clk_gen.sv
bench/island_tb.sv

// ==== rtl/island_boot_rom.sv ====
/*
 * Island boot ROM
 * Registered read of the fixed boot table, aliased over its 4 KiB window
 */

module island_boot_rom (
  input  logic                                    clk_i,
  input  logic                                    sel_i,
  input  logic [island_map_pkg::BankWordBits-1:0] word_i,
  output logic [island_bus_pkg::DataWidth-1:0]    rdata_o
);

  logic [$clog2(island_map_pkg::RomWords)-1:0] idx;

  // Upper word bits ignored so the table repeats
  assign idx = word_i[$clog2(island_map_pkg::RomWords)-1:0];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= island_map_pkg::BootRomTable[idx];
    end
  end

endmodule

// ==== rtl/island_bus_ctrl.sv ====
/*
 * Island bus controller
 * Decodes each Wishbone access to a bank, the SoC registers, the boot
 * ROM or the error response, and answers after a fixed two cycles
 */

module island_bus_ctrl (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Wishbone slave
  input  logic                                    wb_cyc_i,
  input  logic                                    wb_stb_i,
  input  logic                                    wb_we_i,
  input  logic [island_bus_pkg::SelWidth-1:0]     wb_sel_i,
  input  logic [island_bus_pkg::AddrWidth-1:0]    wb_adr_i,
  input  logic [island_bus_pkg::DataWidth-1:0]    wb_dat_i,
  output logic [island_bus_pkg::DataWidth-1:0]    wb_dat_o,
  output logic                                    wb_ack_o,
  output logic                                    wb_err_o,
  // Target strobes
  output logic                                    bank0_sel_o,
  output logic                                    bank1_sel_o,
  output logic                                    regs_sel_o,
  output logic                                    rom_sel_o,
  // Shared access fields
  output logic                                    acc_we_o,
  output logic [island_bus_pkg::SelWidth-1:0]     acc_be_o,
  output logic [island_map_pkg::BankWordBits-1:0] acc_word_o,
  output logic [11:0]                             acc_off_o,
  output logic [island_bus_pkg::DataWidth-1:0]    acc_wdata_o,
  // Target read data
  input  logic [island_bus_pkg::DataWidth-1:0]    bank0_rdata_i,
  input  logic [island_bus_pkg::DataWidth-1:0]    bank1_rdata_i,
  input  logic [island_bus_pkg::DataWidth-1:0]    regs_rdata_i,
  input  logic [island_bus_pkg::DataWidth-1:0]    rom_rdata_i
);

  island_map_pkg::island_addr_t adr;
  island_map_pkg::island_addr_t bank0_base;
  island_map_pkg::island_addr_t bank1_base;
  island_map_pkg::island_addr_t regs_base;
  island_map_pkg::island_addr_t rom_base;

  logic       start;
  logic [3:0] hit;
  logic [3:0] sel_q;
  logic [3:0] rsel_q;
  logic       miss_q;
  logic       busy_q;
  logic       ack_q;
  logic       err_q;

  // ------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------

  assign adr        = wb_adr_i;
  assign bank0_base = island_map_pkg::Bank0Base;
  assign bank1_base = island_map_pkg::Bank1Base;
  assign regs_base  = island_map_pkg::PeriphBase + island_map_pkg::SocCtrlOffset;
  assign rom_base   = island_map_pkg::PeriphBase + island_map_pkg::BootRomOffset;

  // One-hot target: bank0, bank1, regs, rom
  assign hit[0] = (adr.mem.region == bank0_base.mem.region) && (adr.mem.bank == bank0_base.mem.bank);
  assign hit[1] = (adr.mem.region == bank1_base.mem.region) && (adr.mem.bank == bank1_base.mem.bank);
  assign hit[2] = (adr.periph.region == regs_base.periph.region) &&
                  (adr.periph.psel == regs_base.periph.psel);
  assign hit[3] = (adr.periph.region == rom_base.periph.region) &&
                  (adr.periph.psel == rom_base.periph.psel);

  // Held stb during the ack cycle must not start a second access
  assign start = wb_cyc_i & wb_stb_i & ~busy_q;

  // Master holds these until ack or err
  assign acc_we_o    = wb_we_i;
  assign acc_be_o    = wb_sel_i;
  assign acc_word_o  = adr.mem.word;
  assign acc_off_o   = adr.periph.offset;
  assign acc_wdata_o = wb_dat_i;

  assign bank0_sel_o = sel_q[0];
  assign bank1_sel_o = sel_q[1];
  assign regs_sel_o  = sel_q[2];
  assign rom_sel_o   = sel_q[3];

  // ------------------------------------------------------------------
  // Strobe and response sequencing
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= '0;
      rsel_q <= '0;
      miss_q <= 1'b0;
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      sel_q  <= start ? hit : 4'b0000;
      miss_q <= start & ~(|hit);
      ack_q  <= |sel_q;
      err_q  <= miss_q;
      if (start) begin
        busy_q <= 1'b1;
        rsel_q <= hit;
      end else if (ack_q || err_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

  always_comb begin
    if (err_q) begin
      wb_dat_o = island_bus_pkg::ErrorData;
    end else if (rsel_q[0]) begin
      wb_dat_o = bank0_rdata_i;
    end else if (rsel_q[1]) begin
      wb_dat_o = bank1_rdata_i;
    end else if (rsel_q[2]) begin
      wb_dat_o = regs_rdata_i;
    end else if (rsel_q[3]) begin
      wb_dat_o = rom_rdata_i;
    end else begin
      wb_dat_o = '0;
    end
  end

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(wb_ack_o && wb_err_o))
    else $error("ack and err high together");

  // Master must still be holding its request when the answer arrives
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_ack_o || wb_err_o) |-> (wb_cyc_i && wb_stb_i))
    else $error("response outside an active cycle");

endmodule

// ==== rtl/island_bus_pkg.sv ====
/*
 * Island bus definitions
 * Widths of the Wishbone slave port and the fixed error response word
 */

package island_bus_pkg;

  // ------------------------------------------------------------------
  // Port widths
  // ------------------------------------------------------------------

  // Data and address widths of the Wishbone port
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;

  // One select line per byte lane
  localparam int unsigned SelWidth = DataWidth / 8;

  // ------------------------------------------------------------------
  // Fixed responses
  // ------------------------------------------------------------------

  // Read data returned along with an error
  localparam logic [DataWidth-1:0] ErrorData = 32'hBADCAB1E;

endpackage

// ==== rtl/island_map_pkg.sv ====
/*
 * Island address map
 * Bank and peripheral bases, SoC control reset values, boot ROM
 * contents and the two decoded views of a bus address
 */

package island_map_pkg;

  // ------------------------------------------------------------------
  // Memory banks
  // ------------------------------------------------------------------

  localparam int unsigned BankNumBytes = 4096;
  localparam int unsigned BankWordBits = $clog2(BankNumBytes) - 2;

  localparam logic [island_bus_pkg::AddrWidth-1:0] Bank0Base = 32'h0000_0000;
  localparam logic [island_bus_pkg::AddrWidth-1:0] Bank1Base = 32'h0000_1000;

  // ------------------------------------------------------------------
  // Peripheral region, 4 KiB per peripheral
  // ------------------------------------------------------------------

  localparam logic [island_bus_pkg::AddrWidth-1:0] PeriphBase    = 32'h0020_0000;
  localparam logic [island_bus_pkg::AddrWidth-1:0] SocCtrlOffset = 32'h0000_0000;
  localparam logic [island_bus_pkg::AddrWidth-1:0] BootRomOffset = 32'h0000_1000;

  // SoC control register offsets
  localparam logic [11:0] RegFetchEnOffset  = 12'h000;
  localparam logic [11:0] RegBootAddrOffset = 12'h004;

  // Core starts in the boot ROM window, which aliases back to word 0
  localparam logic [island_bus_pkg::AddrWidth-1:0] BootAddrDefault =
    PeriphBase + BootRomOffset + 32'h80;

  // ------------------------------------------------------------------
  // Boot ROM
  // ------------------------------------------------------------------

  localparam int unsigned RomWords = 16;

  // Wait for fetch enable, then jump to the boot address register
  localparam logic [island_bus_pkg::DataWidth-1:0] BootRomTable [RomWords] = '{
    32'h0020_02b7, 32'h0002_a303, 32'hfe03_0ee3, 32'h0042_a383,
    32'h0003_8067, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_006f
  };

  // ------------------------------------------------------------------
  // Address views
  // ------------------------------------------------------------------

  typedef union packed {
    struct packed {
      logic [island_bus_pkg::AddrWidth-BankWordBits-4:0] region;
      logic                                              bank;
      logic [BankWordBits-1:0]                           word;
      logic [1:0]                                        boff;
    } mem;
    struct packed {
      logic [15:0] region;
      logic [3:0]  psel;
      logic [11:0] offset;
    } periph;
  } island_addr_t;

endpackage

// ==== rtl/island_soc_regs.sv ====
/*
 * Island SoC control registers
 * Fetch enable and boot address, with byte-enabled writes and readback
 */

module island_soc_regs (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 sel_i,
  input  logic                                 we_i,
  input  logic [island_bus_pkg::SelWidth-1:0]  be_i,
  input  logic [11:0]                          off_i,
  input  logic [island_bus_pkg::DataWidth-1:0] wdata_i,
  output logic [island_bus_pkg::DataWidth-1:0] rdata_o,
  output logic                                 fetch_en_o,
  output logic [island_bus_pkg::AddrWidth-1:0] boot_addr_o
);

  logic                                 fetch_en_q;
  logic [island_bus_pkg::AddrWidth-1:0] boot_addr_q;
  logic                                 wr_fetch_en;
  logic                                 wr_boot_addr;

  assign wr_fetch_en  = sel_i & we_i & (off_i == island_map_pkg::RegFetchEnOffset);
  assign wr_boot_addr = sel_i & we_i & (off_i == island_map_pkg::RegBootAddrOffset);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q  <= 1'b0;
      boot_addr_q <= island_map_pkg::BootAddrDefault;
    end else begin
      if (wr_fetch_en && be_i[0]) begin
        fetch_en_q <= wdata_i[0];
      end
      if (wr_boot_addr) begin
        for (int b = 0; b < island_bus_pkg::SelWidth; b++) begin
          if (be_i[b]) begin
            boot_addr_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Readback, unmapped offsets read zero
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      case (off_i)
        island_map_pkg::RegFetchEnOffset:  rdata_o <= {{(island_bus_pkg::DataWidth-1){1'b0}}, fetch_en_q};
        island_map_pkg::RegBootAddrOffset: rdata_o <= boot_addr_q;
        default:                           rdata_o <= '0;
      endcase
    end
  end

  assign fetch_en_o  = fetch_en_q;
  assign boot_addr_o = boot_addr_q;

endmodule

// ==== rtl/island_sram_bank.sv ====
/*
 * Island SRAM bank
 * Word-addressed memory with byte-enabled writes and a registered read
 */

module island_sram_bank (
  input  logic                                    clk_i,
  input  logic                                    sel_i,
  input  logic                                    we_i,
  input  logic [island_bus_pkg::SelWidth-1:0]     be_i,
  input  logic [island_map_pkg::BankWordBits-1:0] word_i,
  input  logic [island_bus_pkg::DataWidth-1:0]    wdata_i,
  output logic [island_bus_pkg::DataWidth-1:0]    rdata_o
);

  logic [island_bus_pkg::DataWidth-1:0] mem_q [2**island_map_pkg::BankWordBits];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        for (int b = 0; b < island_bus_pkg::SelWidth; b++) begin
          if (be_i[b]) begin
            mem_q[word_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // Old contents on a write, ignored upstream
      rdata_o <= mem_q[word_i];
    end
  end

  // Controller must hand over clean fields with every strobe
  assert property (@(posedge clk_i) sel_i |-> !$isunknown({we_i, word_i}))
    else $error("unknown control on bank access");

  assert property (@(posedge clk_i) (sel_i && we_i) |-> !$isunknown({be_i, wdata_i}))
    else $error("unknown write data on bank access");

endmodule

// ==== rtl/island_top.sv ====
/*
 * Safety island memory and peripheral subsystem
 * Wishbone slave in front of two SRAM banks, SoC control and boot ROM
 */

module island_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Wishbone slave
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [island_bus_pkg::SelWidth-1:0]  wb_sel_i,
  input  logic [island_bus_pkg::AddrWidth-1:0] wb_adr_i,
  input  logic [island_bus_pkg::DataWidth-1:0] wb_dat_i,
  output logic [island_bus_pkg::DataWidth-1:0] wb_dat_o,
  output logic                                 wb_ack_o,
  output logic                                 wb_err_o,
  // Core control
  output logic                                 fetch_en_o,
  output logic [island_bus_pkg::AddrWidth-1:0] boot_addr_o
);

  logic                                    bank0_sel;
  logic                                    bank1_sel;
  logic                                    regs_sel;
  logic                                    rom_sel;
  logic                                    acc_we;
  logic [island_bus_pkg::SelWidth-1:0]     acc_be;
  logic [island_map_pkg::BankWordBits-1:0] acc_word;
  logic [11:0]                             acc_off;
  logic [island_bus_pkg::DataWidth-1:0]    acc_wdata;
  logic [island_bus_pkg::DataWidth-1:0]    bank0_rdata;
  logic [island_bus_pkg::DataWidth-1:0]    bank1_rdata;
  logic [island_bus_pkg::DataWidth-1:0]    regs_rdata;
  logic [island_bus_pkg::DataWidth-1:0]    rom_rdata;

  // ------------------------------------------------------------------
  // Bus controller
  // ------------------------------------------------------------------

  island_bus_ctrl i_bus_ctrl (
    .clk_i,
    .rst_ni,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_sel_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o,
    .bank0_sel_o   ( bank0_sel   ),
    .bank1_sel_o   ( bank1_sel   ),
    .regs_sel_o    ( regs_sel    ),
    .rom_sel_o     ( rom_sel     ),
    .acc_we_o      ( acc_we      ),
    .acc_be_o      ( acc_be      ),
    .acc_word_o    ( acc_word    ),
    .acc_off_o     ( acc_off     ),
    .acc_wdata_o   ( acc_wdata   ),
    .bank0_rdata_i ( bank0_rdata ),
    .bank1_rdata_i ( bank1_rdata ),
    .regs_rdata_i  ( regs_rdata  ),
    .rom_rdata_i   ( rom_rdata   )
  );

  // ------------------------------------------------------------------
  // Targets
  // ------------------------------------------------------------------

  island_sram_bank i_bank0 (
    .clk_i,
    .sel_i   ( bank0_sel   ),
    .we_i    ( acc_we      ),
    .be_i    ( acc_be      ),
    .word_i  ( acc_word    ),
    .wdata_i ( acc_wdata   ),
    .rdata_o ( bank0_rdata )
  );

  island_sram_bank i_bank1 (
    .clk_i,
    .sel_i   ( bank1_sel   ),
    .we_i    ( acc_we      ),
    .be_i    ( acc_be      ),
    .word_i  ( acc_word    ),
    .wdata_i ( acc_wdata   ),
    .rdata_o ( bank1_rdata )
  );

  island_soc_regs i_soc_regs (
    .clk_i,
    .rst_ni,
    .sel_i   ( regs_sel   ),
    .we_i    ( acc_we     ),
    .be_i    ( acc_be     ),
    .off_i   ( acc_off    ),
    .wdata_i ( acc_wdata  ),
    .rdata_o ( regs_rdata ),
    .fetch_en_o,
    .boot_addr_o
  );

  island_boot_rom i_boot_rom (
    .clk_i,
    .sel_i   ( rom_sel   ),
    .word_i  ( acc_word  ),
    .rdata_o ( rom_rdata )
  );

endmodule
